// ==== src/pgwr_pkg.sv ====
// ==========================================================================
// shared definitions of the page-table write manager
// table sizes, base addresses, entry layouts, enums and port structs
// ==========================================================================

package pgwr_pkg;

	// table geometry, shrunk for simulation
	localparam int unsigned ATT_ENTRY_CNT  = 16;
	localparam int unsigned LIST_ENTRY_CNT = 8;
	localparam int unsigned ATT_PER_LINE   = 8;  // 64-bit entries per 64-byte line
	localparam int unsigned LIST_PER_LINE  = 4;  // 128-bit entries per line

	localparam logic [63:0] ATT_BASE  = 64'h0000_0000_8000_0000;
	localparam logic [63:0] LIST_BASE = 64'h0000_0000_8000_1000;

	localparam logic [49:0] PPA_BASE_PAGE = 50'h0_0000_0008_0200;  // page of list entry 1

	typedef logic [23:0] ptr_t;  // list pointer or one-based entry id

	localparam ptr_t NULL_PTR = '0;

	typedef enum logic [1:0] {
		STS_DALLOC = 2'd0,
		STS_UNCOMP = 2'd1,
		STS_COMP   = 2'd2
	} att_sts_e;

	typedef enum logic [1:0] {LST_NONE, LST_FREE, LST_UNCOMP, LST_NULLIFY} list_id_e;

	typedef enum logic [2:0] {
		OP_ATT_INIT, OP_LIST_INIT, OP_ATT_UPD, OP_POP_HEAD,
		OP_PUSH_ENTRY, OP_NULLIFY, OP_LINK_TAIL
	} wr_op_e;

	// address phase / data phase pairs
	typedef enum logic [3:0] {
		ST_IDLE, ST_INIT_ATT, ST_WAIT_ATT, ST_INIT_LIST, ST_WAIT_LIST,
		ST_ATT_UPD, ST_WAIT_ATT_UPD, ST_POP, ST_WAIT_POP, ST_PUSH, ST_WAIT_PUSH,
		ST_LINK, ST_WAIT_LINK, ST_WAIT_BRESP
	} mngr_state_e;

	typedef struct packed {
		logic [11:0] zpd_cnt;
		logic [49:0] way;
		att_sts_e    sts;  // bits 1:0
	} att_entry_t;

	typedef struct packed {
		logic [5:0]  rsvd;
		logic [49:0] way;
		ptr_t        att_id;
		ptr_t        prev;
		ptr_t        next;  // bytes 0..2
	} list_entry_t;

	typedef struct packed {
		logic         awvalid;
		logic         wvalid;
		logic [63:0]  addr;
		logic [511:0] data;
		logic [63:0]  strb;
	} wr_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
	} wr_rdy_t;

	typedef struct packed {
		logic       bvalid;
		logic [1:0] bresp;
	} wr_resp_t;

	typedef struct packed {
		logic        valid;     // one-cycle strobe
		ptr_t        att_id;
		ptr_t        tol_id;    // list entry being moved
		list_id_e    src_list;
		list_id_e    dst_list;
		list_entry_t entry;     // current way, prev and next of tol_id
		logic [11:0] zpd_cnt;
	} upd_req_t;

	typedef struct packed {
		logic do_pop;
		logic clear_src;
		logic dst_first;
		logic dst_link;
	} upd_plan_t;

	typedef struct packed {
		ptr_t free_head;
		ptr_t free_tail;
		ptr_t uncomp_head;
		ptr_t uncomp_tail;
	} list_ht_t;

	typedef struct packed {
		logic init_free;
		logic pop_src;
		logic clear_src;
		logic push_first;
		logic push_tail;
	} ht_cmd_t;

endpackage

// ==== src/pgwr_upd_decode.sv ====
// ==========================================================================
// update request decoder
// latches a table-update request and derives its write plan from the
// current list heads and tails
// ==========================================================================
`timescale 1ns/1ps

module pgwr_upd_decode import pgwr_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_ni,
	input  upd_req_t  upd_req,
	input  list_ht_t  list_ht,
	input  logic      accept,
	output upd_req_t  req_q,
	output upd_plan_t plan
);

	ptr_t src_head;
	ptr_t src_tail;
	logic pop_n;    // source holds more than one entry
	logic first_n;  // destination uncompressed list ends up empty before the push
	logic dst_unc;

	always_comb begin
		case (upd_req.src_list)
			LST_FREE: begin
				src_head = list_ht.free_head;
				src_tail = list_ht.free_tail;
			end
			LST_UNCOMP: begin
				src_head = list_ht.uncomp_head;
				src_tail = list_ht.uncomp_tail;
			end
			default: begin  // not a legal source
				src_head = NULL_PTR;
				src_tail = NULL_PTR;
			end
		endcase
	end

	assign pop_n   = src_head != src_tail;
	assign dst_unc = upd_req.dst_list == LST_UNCOMP;
	// a single-entry uncompressed source is cleared before the push
	assign first_n = dst_unc && ((list_ht.uncomp_tail == NULL_PTR) ||
	                 ((upd_req.src_list == LST_UNCOMP) && !pop_n));

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			plan <= '0;
		end else if (accept) begin
			plan.do_pop    <= pop_n;
			plan.clear_src <= !pop_n;
			plan.dst_first <= first_n;
			plan.dst_link  <= dst_unc && !first_n;  // old tail gets its next pointer
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) req_q <= upd_req;  // held for the whole update
	end

	// only the free and uncompressed lists can give up an entry
	a_src_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
		accept |-> !(upd_req.src_list inside {LST_NONE, LST_NULLIFY}));

endmodule

// ==== src/tbl_wr_format.sv ====
// ==========================================================================
// table write formatter
// forms line address, data and byte strobes for one ATT or list-table
// write from the operation, entry index, latched request and list pointers
// ==========================================================================
`timescale 1ns/1ps

module tbl_wr_format import pgwr_pkg::*; (
	input  wr_op_e   op,
	input  ptr_t     entry_idx,
	input  upd_req_t req_q,
	input  list_ht_t list_ht,
	output wr_req_t  pld        // addr, data and strb only
);

	ptr_t        id;        // one-based target entry
	logic        is_att;    // ATT table vs list table
	ptr_t        off;
	logic [2:0]  slot;      // entry position inside the line
	logic [63:0] line_addr;
	att_entry_t  att_e;
	list_entry_t lst_e;
	logic [15:0] lst_mask;  // byte enables inside one list entry
	logic        fr2unc;

	assign fr2unc = (req_q.src_list == LST_FREE) && (req_q.dst_list == LST_UNCOMP);

	always_comb begin
		id       = entry_idx;
		is_att   = 1'b1;
		att_e    = '0;
		lst_e    = '0;
		lst_mask = '0;
		case (op)
			OP_ATT_INIT: begin
				att_e.sts = STS_DALLOC;  // way and zpd_cnt stay zero
			end
			OP_LIST_INIT: begin
				is_att    = 1'b0;
				lst_e.way = PPA_BASE_PAGE + 50'(entry_idx) - 50'd1;
				lst_e.prev = entry_idx - ptr_t'(1);  // entry 1 gets NULL
				lst_e.next = (entry_idx == ptr_t'(LIST_ENTRY_CNT)) ? NULL_PTR :
				             entry_idx + ptr_t'(1);
				lst_mask  = 16'hFFFF;
			end
			OP_ATT_UPD: begin
				id            = req_q.att_id;
				att_e.way     = req_q.entry.way;  // list way becomes the page's way
				att_e.sts     = fr2unc ? STS_UNCOMP : STS_COMP;
				att_e.zpd_cnt = fr2unc ? req_q.zpd_cnt : 12'd0;
			end
			OP_POP_HEAD: begin
				// next neighbour takes over our prev and becomes head
				is_att     = 1'b0;
				id         = req_q.entry.next;
				lst_e.prev = req_q.entry.prev;
				lst_mask   = 16'h0038;  // prev bytes
			end
			OP_PUSH_ENTRY: begin
				is_att       = 1'b0;
				id           = req_q.tol_id;
				lst_e.next   = NULL_PTR;
				lst_e.prev   = list_ht.uncomp_tail;
				lst_e.att_id = req_q.att_id;
				lst_mask     = 16'h01FF;  // next, prev, att_id
			end
			OP_NULLIFY: begin
				is_att       = 1'b0;
				id           = req_q.tol_id;
				lst_e.att_id = req_q.att_id;  // entry is detached from every list
				lst_mask     = 16'h01FF;
			end
			OP_LINK_TAIL: begin
				is_att     = 1'b0;
				id         = list_ht.uncomp_tail;  // old tail
				lst_e.next = req_q.tol_id;
				lst_mask   = 16'h0007;
			end
			default: ;
		endcase
	end

	// line and slot of a one-based id
	assign off  = id - ptr_t'(1);
	assign slot = is_att ? 3'(off % ptr_t'(ATT_PER_LINE)) : 3'(off % ptr_t'(LIST_PER_LINE));

	assign line_addr = is_att ? ATT_BASE + (64'(off / ptr_t'(ATT_PER_LINE)) << 6) :
	                            LIST_BASE + (64'(off / ptr_t'(LIST_PER_LINE)) << 6);

	always_comb begin
		pld      = '0;
		pld.addr = line_addr;
		if (is_att) begin
			pld.data = 512'(att_e) << (64 * slot);
			pld.strb = 64'(8'hFF) << (8 * slot);
		end else begin
			pld.data = 512'(lst_e) << (128 * slot);
			pld.strb = 64'(lst_mask) << (16 * slot);
		end
	end

endmodule

// ==== src/pgwr_seq_fsm.sv ====
// ==========================================================================
// write sequencer
// steps through ATT init, list init and table updates as address/data
// phase pairs, holds the payload and drives the write strobes
// ==========================================================================
`timescale 1ns/1ps

module pgwr_seq_fsm import pgwr_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_ni,
	input  logic      init_att,
	input  logic      init_list,
	input  logic      upd_valid,
	input  upd_plan_t plan,
	input  list_id_e  dst_list,
	input  wr_rdy_t   wr_rdy,
	input  logic      all_done,
	input  wr_req_t   pld,
	output wr_op_e    op,
	output ptr_t      entry_idx,
	output logic      accept,
	output ht_cmd_t   ht_cmd,
	output wr_req_t   wr_req,
	output logic      init_att_done,
	output logic      init_list_done,
	output logic      mngr_ready,
	output logic      tbl_update_done
);

	mngr_state_e state_q, state_d;
	ptr_t        cnt_q, cnt_d;      // init entry counter
	logic        aw_q, aw_d;
	logic        w_q, w_d;
	logic        ld_pld;
	logic        att_set, list_set;
	logic        aw_ok, w_ok;
	wr_req_t     pld_q;

	assign aw_ok = wr_rdy.awready && !aw_q;
	assign w_ok  = wr_rdy.wready && !w_q;

	always_comb begin
		case (state_q)
			ST_INIT_ATT:  op = OP_ATT_INIT;
			ST_INIT_LIST: op = OP_LIST_INIT;
			ST_ATT_UPD:   op = OP_ATT_UPD;
			ST_POP:       op = OP_POP_HEAD;
			ST_PUSH:      op = (dst_list == LST_UNCOMP) ? OP_PUSH_ENTRY : OP_NULLIFY;
			ST_LINK:      op = OP_LINK_TAIL;
			default:      op = OP_ATT_INIT;
		endcase
	end
	assign entry_idx = cnt_q;

	always_comb begin
		state_d  = state_q;
		cnt_d    = cnt_q;
		aw_d     = 1'b0;  // strobes are single-cycle pulses
		w_d      = 1'b0;
		ld_pld   = 1'b0;
		accept   = 1'b0;
		att_set  = 1'b0;
		list_set = 1'b0;
		ht_cmd   = '0;
		case (state_q)
			ST_IDLE: begin
				if (init_att && !init_att_done) begin
					state_d = ST_INIT_ATT;
					cnt_d   = ptr_t'(1);
				end else if (init_list && !init_list_done) begin
					state_d = ST_INIT_LIST;
					cnt_d   = ptr_t'(1);
				end else if (upd_valid) begin
					accept  = 1'b1;
					state_d = ST_ATT_UPD;
				end
			end
			ST_INIT_ATT: begin
				if (cnt_q > ptr_t'(ATT_ENTRY_CNT)) begin  // all entries written
					att_set = 1'b1;
					state_d = ST_IDLE;
				end else if (aw_ok) begin
					{ld_pld, aw_d} = 2'b11;
					cnt_d   = cnt_q + ptr_t'(1);
					state_d = ST_WAIT_ATT;
				end
			end
			ST_INIT_LIST: begin
				if (cnt_q > ptr_t'(LIST_ENTRY_CNT)) begin
					list_set         = 1'b1;
					ht_cmd.init_free = 1'b1;  // whole table is one free list
					state_d          = ST_IDLE;
				end else if (aw_ok) begin
					{ld_pld, aw_d} = 2'b11;
					cnt_d   = cnt_q + ptr_t'(1);
					state_d = ST_WAIT_LIST;
				end
			end
			ST_WAIT_ATT:  if (w_ok) {w_d, state_d} = {1'b1, ST_INIT_ATT};
			ST_WAIT_LIST: if (w_ok) {w_d, state_d} = {1'b1, ST_INIT_LIST};
			ST_ATT_UPD:   if (aw_ok) {ld_pld, aw_d, state_d} = {2'b11, ST_WAIT_ATT_UPD};
			ST_POP:       if (aw_ok) {ld_pld, aw_d, state_d} = {2'b11, ST_WAIT_POP};
			ST_PUSH:      if (aw_ok) {ld_pld, aw_d, state_d} = {2'b11, ST_WAIT_PUSH};
			ST_LINK:      if (aw_ok) {ld_pld, aw_d, state_d} = {2'b11, ST_WAIT_LINK};
			ST_WAIT_ATT_UPD: begin
				if (w_ok) begin
					w_d              = 1'b1;
					ht_cmd.clear_src = plan.clear_src;  // single-entry source empties
					state_d          = plan.do_pop ? ST_POP : ST_PUSH;
				end
			end
			ST_WAIT_POP: begin
				if (w_ok) begin
					w_d            = 1'b1;
					ht_cmd.pop_src = 1'b1;
					state_d        = ST_PUSH;
				end
			end
			ST_WAIT_PUSH: begin
				if (w_ok) begin
					w_d               = 1'b1;
					ht_cmd.push_first = plan.dst_first;
					state_d           = plan.dst_link ? ST_LINK : ST_WAIT_BRESP;
				end
			end
			ST_WAIT_LINK: begin
				if (w_ok) begin
					w_d              = 1'b1;
					ht_cmd.push_tail = 1'b1;  // tail moves only after the link write is loaded
					state_d          = ST_WAIT_BRESP;
				end
			end
			ST_WAIT_BRESP: if (all_done) state_d = ST_IDLE;
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q        <= ST_IDLE;
			cnt_q          <= NULL_PTR;
			aw_q           <= 1'b0;
			w_q            <= 1'b0;
			init_att_done  <= 1'b0;
			init_list_done <= 1'b0;
		end else begin
			state_q        <= state_d;
			cnt_q          <= cnt_d;
			aw_q           <= aw_d;
			w_q            <= w_d;
			init_att_done  <= init_att_done | att_set;  // sticky
			init_list_done <= init_list_done | list_set;
		end
	end

	always_ff @(posedge clk_i) begin
		if (ld_pld) pld_q <= pld;  // stable until the next write is loaded
	end

	always_comb begin
		wr_req         = pld_q;
		wr_req.awvalid = aw_q;
		wr_req.wvalid  = w_q;
	end

	assign mngr_ready      = state_q == ST_IDLE;
	assign tbl_update_done = (state_q == ST_WAIT_BRESP) && all_done;

	// address and data phases of the strobe scheme never overlap
	a_no_aw_w: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(wr_req.awvalid && wr_req.wvalid));

endmodule

// ==== src/list_ht_regs.sv ====
// ==========================================================================
// head and tail pointers of the free and uncompressed lists
// updated by one-cycle commands from the sequencer
// ==========================================================================
`timescale 1ns/1ps

module list_ht_regs import pgwr_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  ht_cmd_t  ht_cmd,
	input  upd_req_t req_q,
	output list_ht_t list_ht
);

	logic src_free;
	logic src_unc;

	assign src_free = req_q.src_list == LST_FREE;
	assign src_unc  = req_q.src_list == LST_UNCOMP;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			list_ht <= '{default: NULL_PTR};  // all lists empty
		end else begin
			if (ht_cmd.init_free) begin
				list_ht.free_head <= ptr_t'(1);
				list_ht.free_tail <= ptr_t'(LIST_ENTRY_CNT);
			end
			if (ht_cmd.pop_src) begin  // our next becomes the head
				if (src_free) list_ht.free_head   <= req_q.entry.next;
				if (src_unc)  list_ht.uncomp_head <= req_q.entry.next;
			end
			if (ht_cmd.clear_src && src_free) begin
				list_ht.free_head <= NULL_PTR;
				list_ht.free_tail <= NULL_PTR;
			end
			if (ht_cmd.clear_src && src_unc) begin
				list_ht.uncomp_head <= NULL_PTR;
				list_ht.uncomp_tail <= NULL_PTR;
			end
			if (ht_cmd.push_first) begin
				list_ht.uncomp_head <= req_q.tol_id;
				list_ht.uncomp_tail <= req_q.tol_id;
			end
			if (ht_cmd.push_tail) list_ht.uncomp_tail <= req_q.tol_id;
		end
	end

endmodule

// ==== src/wr_resp_tracker.sv ====
// ==========================================================================
// write response tracker
// counts outstanding writes, keeps a sticky bus error
// ==========================================================================
`timescale 1ns/1ps

module wr_resp_tracker import pgwr_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  wr_req_t  wr_req,
	input  wr_rdy_t  wr_rdy,
	input  wr_resp_t wr_resp,
	output logic     all_done,
	output logic     bus_error
);

	logic [6:0] out_cnt;  // up to 64 lines in flight
	logic       aw_acc;
	logic       retire;

	// awvalid is only pulsed after awready was seen, so every pulse is a write
	assign aw_acc = wr_req.awvalid;
	// responses are in order, error responses retire their write too
	assign retire = wr_resp.bvalid && (out_cnt != 7'd0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			out_cnt   <= 7'd0;
			bus_error <= 1'b0;
		end else begin
			case ({aw_acc, retire})
				2'b10:   out_cnt <= out_cnt + 7'd1;
				2'b01:   out_cnt <= out_cnt - 7'd1;
				default: ;  // none or both
			endcase
			// bad status or a response nobody is waiting for
			if (wr_resp.bvalid && ((wr_resp.bresp != 2'b00) || (out_cnt == 7'd0)))
				bus_error <= 1'b1;
		end
	end

	assign all_done = out_cnt == 7'd0;

	a_cnt_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
		out_cnt <= 7'd64);

endmodule

// ==== src/pgwr_mngr.sv ====
// ==========================================================================
// page-table write manager top
// request decoder, write formatter, sequencer, list pointers and
// response tracker
// ==========================================================================
`timescale 1ns/1ps

module pgwr_mngr import pgwr_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  logic     init_att,
	input  logic     init_list,
	input  upd_req_t upd_req,
	input  wr_rdy_t  wr_rdy,
	input  wr_resp_t wr_resp,
	output wr_req_t  wr_req,
	output list_ht_t list_ht,
	output logic     init_att_done,
	output logic     init_list_done,
	output logic     mngr_ready,
	output logic     tbl_update_done,
	output logic     bus_error
);

	logic      accept;
	logic      all_done;
	upd_req_t  req_q;     // latched request
	upd_plan_t plan;
	wr_op_e    op;
	ptr_t      entry_idx;
	wr_req_t   pld;       // formatted payload, combinational
	ht_cmd_t   ht_cmd;

	pgwr_upd_decode u_decode (
		.clk_i, .rst_ni,
		.upd_req, .list_ht, .accept,
		.req_q, .plan
	);

	tbl_wr_format u_format (
		.op, .entry_idx, .req_q, .list_ht,
		.pld
	);

	pgwr_seq_fsm u_seq (
		.clk_i, .rst_ni,
		.init_att, .init_list,
		.upd_valid (upd_req.valid),
		.plan,
		.dst_list  (req_q.dst_list),
		.wr_rdy, .all_done, .pld,
		.op, .entry_idx, .accept, .ht_cmd, .wr_req,
		.init_att_done, .init_list_done, .mngr_ready, .tbl_update_done
	);

	list_ht_regs u_ht (
		.clk_i, .rst_ni,
		.ht_cmd, .req_q,
		.list_ht
	);

	wr_resp_tracker u_resp (
		.clk_i, .rst_ni,
		.wr_req, .wr_rdy, .wr_resp,
		.all_done, .bus_error
	);

endmodule

// ==== test/pgwr_checker.sv ====
// ==========================================================================
// testbench checker with its own list-table model
// predicts every ATT and list-table write plus the resulting list pointers
// ==========================================================================
`timescale 1ns/1ps

module pgwr_checker import pgwr_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_ni,
	input  wr_req_t         wr_req,
	input  upd_req_t        upd_req,
	input  logic            mngr_ready,
	input  list_ht_t        list_ht,
	input  logic            init_att_done,
	input  logic            init_list_done,
	input  logic            tbl_update_done,
	input  logic            bus_error,
	input  logic [8*16-1:0] test_name,
	input  list_ht_t        exp_ht,     // expected pointers from the stimulus table
	input  logic            err_row,    // current row gets error responses
	output int              err_cnt,
	output int              pending     // predicted writes not yet seen
);

	wr_req_t  exp_q[$];
	ptr_t     lst_next [0:LIST_ENTRY_CNT];
	ptr_t     lst_prev [0:LIST_ENTRY_CNT];
	list_ht_t mdl;        // model heads and tails
	logic     err_seen;   // an error response was already sent
	logic     att_seen;
	logic     list_seen;

	// one mask bit per data bit from the byte strobes
	function automatic logic [511:0] byte_mask(input logic [63:0] s);
		logic [511:0] m;
		for (int i = 0; i < 64; i++) m[8*i +: 8] = {8{s[i]}};
		return m;
	endfunction

	function automatic wr_req_t att_wr(input ptr_t id, input att_entry_t e);
		wr_req_t     w;
		int unsigned slot;
		w      = '0;
		slot   = (id - 1) % ATT_PER_LINE;
		w.addr = ATT_BASE + 64'((id - 1) / ATT_PER_LINE) * 64;
		w.data = 512'(e) << (64 * slot);
		w.strb = 64'hFF << (8 * slot);  // the whole 64-bit entry
		return w;
	endfunction

	function automatic wr_req_t list_wr(input ptr_t id, input list_entry_t e,
		input logic [15:0] bm);
		wr_req_t     w;
		int unsigned slot;
		w      = '0;
		slot   = (id - 1) % LIST_PER_LINE;
		w.addr = LIST_BASE + 64'((id - 1) / LIST_PER_LINE) * 64;
		w.data = 512'(e) << (128 * slot);
		w.strb = 64'(bm) << (16 * slot);
		return w;
	endfunction

	task automatic report_ht(input string what, input list_ht_t exp);
		if (list_ht !== exp) begin
			err_cnt++;
			$display("error %0s: %0s expected %h actual %h", test_name, what, exp, list_ht);
		end
	endtask

	// queue the writes of one update and move the model along
	task automatic predict_update();
		ptr_t        tol;
		ptr_t        nb;
		ptr_t        sh;
		ptr_t        st;
		logic        src_free;
		logic        f2u;
		att_entry_t  a;
		list_entry_t e;
		tol      = upd_req.tol_id;
		src_free = upd_req.src_list == LST_FREE;
		f2u      = src_free && (upd_req.dst_list == LST_UNCOMP);
		sh       = src_free ? mdl.free_head : mdl.uncomp_head;
		st       = src_free ? mdl.free_tail : mdl.uncomp_tail;
		if (tol != sh) begin
			err_cnt++;
			$display("%0s: moved entry %0d is not the head of its source list", test_name, tol);
		end
		a         = '0;
		a.way     = PPA_BASE_PAGE + 50'(tol) - 50'd1;  // ways never move
		a.sts     = f2u ? STS_UNCOMP : STS_COMP;
		a.zpd_cnt = f2u ? upd_req.zpd_cnt : 12'd0;
		exp_q.push_back(att_wr(upd_req.att_id, a));
		if (sh != st) begin  // pop, neighbour becomes head
			nb     = lst_next[tol];
			e      = '0;
			e.prev = lst_prev[tol];
			exp_q.push_back(list_wr(nb, e, 16'h0038));
			lst_prev[nb] = lst_prev[tol];
			if (src_free) mdl.free_head = nb;
			else mdl.uncomp_head = nb;
		end else if (src_free) begin
			mdl.free_head = NULL_PTR;
			mdl.free_tail = NULL_PTR;
		end else begin
			mdl.uncomp_head = NULL_PTR;
			mdl.uncomp_tail = NULL_PTR;
		end
		e        = '0;
		e.att_id = upd_req.att_id;
		if (upd_req.dst_list == LST_UNCOMP) begin
			e.prev = mdl.uncomp_tail;
			exp_q.push_back(list_wr(tol, e, 16'h01FF));
			lst_next[tol] = NULL_PTR;
			lst_prev[tol] = mdl.uncomp_tail;
			if (mdl.uncomp_tail == NULL_PTR) begin  // list was empty
				mdl.uncomp_head = tol;
				mdl.uncomp_tail = tol;
			end else begin
				e      = '0;
				e.next = tol;
				exp_q.push_back(list_wr(mdl.uncomp_tail, e, 16'h0007));
				lst_next[mdl.uncomp_tail] = tol;
				mdl.uncomp_tail = tol;
			end
		end else begin  // nullified, detached from all lists
			exp_q.push_back(list_wr(tol, e, 16'h01FF));
			lst_next[tol] = NULL_PTR;
			lst_prev[tol] = NULL_PTR;
		end
		pending = exp_q.size();
	endtask

	task automatic compare_write();
		wr_req_t      x;
		logic [511:0] m;
		if (exp_q.size() == 0) begin
			err_cnt++;
			$display("%0s: table write to %h that no operation asked for", test_name, wr_req.addr);
			return;
		end
		x       = exp_q.pop_front();
		pending = exp_q.size();
		m       = byte_mask(x.strb);
		if (wr_req.addr !== x.addr) begin
			err_cnt++;
			$display("error %0s: addr expected %h actual %h", test_name, x.addr, wr_req.addr);
		end
		if (wr_req.strb !== x.strb) begin
			err_cnt++;
			$display("error %0s: strb expected %h actual %h", test_name, x.strb, wr_req.strb);
		end
		if ((wr_req.data & m) !== (x.data & m)) begin
			err_cnt++;
			$display("error %0s: data expected %h actual %h", test_name, x.data & m,
				wr_req.data & m);
		end
	endtask

	initial begin
		list_entry_t e;
		err_cnt   = 0;
		err_seen  = 1'b0;
		att_seen  = 1'b0;
		list_seen = 1'b0;
		mdl       = '0;
		for (int n = 1; n <= ATT_ENTRY_CNT; n++) exp_q.push_back(att_wr(ptr_t'(n), '0));
		for (int n = 1; n <= LIST_ENTRY_CNT; n++) begin  // one long free list
			e      = '0;
			e.way  = PPA_BASE_PAGE + 50'(n) - 50'd1;
			e.prev = ptr_t'(n - 1);
			e.next = (n == LIST_ENTRY_CNT) ? NULL_PTR : ptr_t'(n + 1);
			exp_q.push_back(list_wr(ptr_t'(n), e, 16'hFFFF));
			lst_next[n] = e.next;
			lst_prev[n] = e.prev;
		end
		pending = exp_q.size();
		@(posedge rst_ni);
		@(negedge clk_i);
		if (!mngr_ready || init_att_done || init_list_done || bus_error) begin
			err_cnt++;
			$display("status outputs are not idle right after reset");
		end
		report_ht("list_ht after reset", '0);
	end

	always @(negedge clk_i) begin
		if (rst_ni) begin
			if (upd_req.valid && mngr_ready) predict_update();  // accepted this cycle
			if (wr_req.awvalid) compare_write();
			if (init_att_done && !att_seen) begin
				att_seen = 1'b1;
				if (pending != LIST_ENTRY_CNT) begin
					err_cnt++;
					$display("ATT init finished with %0d ATT writes missing",
						pending - LIST_ENTRY_CNT);
				end
			end
			if (att_seen && !init_att_done) begin
				err_cnt++;
				$display("init_att_done dropped after it was set");
			end
			if (list_seen && !init_list_done) begin
				err_cnt++;
				$display("init_list_done dropped after it was set");
			end
			if (init_list_done && !list_seen) begin
				list_seen     = 1'b1;
				mdl.free_head = ptr_t'(1);
				mdl.free_tail = ptr_t'(LIST_ENTRY_CNT);
				report_ht("list_ht after list init", mdl);
			end
			if (tbl_update_done) begin
				err_seen = err_seen | err_row;
				report_ht("list_ht", exp_ht);
				report_ht("list_ht vs model", mdl);
				if (bus_error !== err_seen) begin
					err_cnt++;
					$display("error %0s: bus_error expected %b actual %b", test_name,
						err_seen, bus_error);
				end
			end
			if (bus_error && !(err_seen || err_row)) begin
				err_cnt++;
				$display("%0s: bus_error rose without any error response", test_name);
			end
		end
	end

endmodule

// ==== test/tb_pgwr_mngr.sv ====
// ==========================================================================
// testbench of the page-table write manager
// clock, reset, write slave, update table loop, watchdog and final report
// ==========================================================================
`timescale 1ns/1ps

module tb_pgwr_mngr import pgwr_pkg::*; ();

	typedef struct packed {
		logic [8*16-1:0] name;
		ptr_t            att_id;
		ptr_t            tol_id;
		list_id_e        src;
		list_id_e        dst;
		logic [11:0]     zpd;
		ptr_t            prv;   // current links of the moved entry
		ptr_t            nxt;
		logic            err;   // answer this row with error responses
		list_ht_t        ht;    // pointers expected afterwards
	} row_t;

	logic            clk_i;
	logic            rst_ni;
	logic            init_att;
	logic            init_list;
	upd_req_t        upd_req;
	wr_rdy_t         wr_rdy;
	wr_resp_t        wr_resp;
	wr_req_t         wr_req;
	list_ht_t        list_ht;
	logic            init_att_done;
	logic            init_list_done;
	logic            mngr_ready;
	logic            tbl_update_done;
	logic            bus_error;
	logic [8*16-1:0] cur_name;
	list_ht_t        exp_ht;
	logic            err_now;
	int              chk_errs;
	int              pending;
	int              tb_errs;
	integer          seed;
	int              cyc;
	row_t            rows[$];
	int              due_q[$];  // response due cycles, in order
	logic            err_q[$];

	pgwr_mngr u_pgwr_mngr (
		.clk_i, .rst_ni, .init_att, .init_list, .upd_req, .wr_rdy, .wr_resp,
		.wr_req, .list_ht, .init_att_done, .init_list_done, .mngr_ready,
		.tbl_update_done, .bus_error
	);

	pgwr_checker u_checker (
		.clk_i, .rst_ni, .wr_req, .upd_req, .mngr_ready, .list_ht,
		.init_att_done, .init_list_done, .tbl_update_done, .bus_error,
		.test_name (cur_name), .exp_ht, .err_row (err_now),
		.err_cnt (chk_errs), .pending
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	task automatic add_row(input logic [8*16-1:0] name, input ptr_t att, input ptr_t tol,
		input list_id_e src, input list_id_e dst, input logic [11:0] zpd,
		input ptr_t prv, input ptr_t nxt, input logic err,
		input ptr_t fh, input ptr_t ft, input ptr_t uh, input ptr_t ut);
		row_t r;
		r = '{name, att, tol, src, dst, zpd, prv, nxt, err, '{fh, ft, uh, ut}};
		rows.push_back(r);
	endtask

	task automatic build_table();
		//      name             att tol src         dst          zpd     prv nxt err  ht
		add_row("f2u_first",     3, 1, LST_FREE,   LST_UNCOMP,  12'h123, 0, 2, 0, 2, 8, 1, 1);
		add_row("f2u_link",      5, 2, LST_FREE,   LST_UNCOMP,  12'h0AB, 0, 3, 0, 3, 8, 1, 2);
		add_row("u2u_move",      3, 1, LST_UNCOMP, LST_UNCOMP,  12'h055, 0, 2, 0, 3, 8, 2, 1);
		add_row("f2null",        7, 3, LST_FREE,   LST_NULLIFY, 12'h000, 0, 4, 0, 4, 8, 2, 1);
		add_row("u2null_err",    5, 2, LST_UNCOMP, LST_NULLIFY, 12'h000, 0, 1, 1, 4, 8, 1, 1);
		add_row("u_single_clr",  3, 1, LST_UNCOMP, LST_NULLIFY, 12'h000, 0, 0, 0, 4, 8, 0, 0);
		add_row("f2u_again",     9, 4, LST_FREE,   LST_UNCOMP,  12'h3FF, 0, 5, 0, 5, 8, 4, 4);
	endtask

	// one request, then wait for its completion pulse
	task automatic run_row(input row_t r);
		@(negedge clk_i);
		while (!mngr_ready) @(negedge clk_i);
		@(posedge clk_i);
		#1;
		cur_name           = r.name;
		exp_ht             = r.ht;
		err_now            = r.err;
		upd_req            = '0;
		upd_req.valid      = 1'b1;
		upd_req.att_id     = r.att_id;
		upd_req.tol_id     = r.tol_id;
		upd_req.src_list   = r.src;
		upd_req.dst_list   = r.dst;
		upd_req.zpd_cnt    = r.zpd;
		upd_req.entry.way  = PPA_BASE_PAGE + 50'(r.tol_id) - 50'd1;
		upd_req.entry.prev = r.prv;
		upd_req.entry.next = r.nxt;
		@(posedge clk_i);
		#1 upd_req.valid = 1'b0;  // one-cycle strobe
		@(negedge clk_i);
		while (!tbl_update_done) @(negedge clk_i);
		@(posedge clk_i);
		#1 err_now = 1'b0;
	endtask

	// write slave with random ready levels and delayed in-order responses
	initial begin : write_slave
		wr_rdy  = '0;
		wr_resp = '0;
		seed    = 39852;
		cyc     = 0;
		forever begin
			@(negedge clk_i);
			if (wr_req.wvalid === 1'b1) begin
				due_q.push_back(cyc + 2 + ($random(seed) & 3));  // 2 to 5 cycles
				err_q.push_back(err_now);
			end
			@(posedge clk_i);
			#1;
			cyc++;
			wr_rdy.awready = ($random(seed) & 3) != 0;  // ready about 3 cycles in 4
			wr_rdy.wready  = ($random(seed) & 3) != 0;
			wr_resp        = '0;
			if (due_q.size() > 0 && due_q[0] <= cyc) begin
				void'(due_q.pop_front());
				wr_resp.bvalid = 1'b1;
				wr_resp.bresp  = err_q.pop_front() ? 2'b10 : 2'b00;  // slave error
			end
		end
	end

	initial begin : watchdog
		int limit;
		#1;
		limit = 8 + 40 * (ATT_ENTRY_CNT + LIST_ENTRY_CNT) + 200 * rows.size();
		repeat (limit) @(posedge clk_i);
		$display("timeout: the DUT did not finish all tests within %0d cycles", limit);
		$display("Test FAILED");
		$finish;
	end

	initial begin : stimulus
		rst_ni    = 1'b0;
		init_att  = 1'b0;
		init_list = 1'b0;
		upd_req   = '0;
		exp_ht    = '0;
		err_now   = 1'b0;
		tb_errs   = 0;
		cur_name  = "reset";
		build_table();
		repeat (8) @(posedge clk_i);
		#1 rst_ni = 1'b1;
		@(posedge clk_i);
		#1;
		cur_name = "att_init";
		init_att = 1'b1;  // level, held high
		wait (init_att_done);
		@(posedge clk_i);
		#1;
		cur_name  = "list_init";
		init_list = 1'b1;
		wait (init_list_done);
		foreach (rows[i]) run_row(rows[i]);
		repeat (10) @(posedge clk_i);  // let stray writes show up
		if (pending != 0) begin
			tb_errs++;
			$display("%0d predicted table writes never appeared on the bus", pending);
		end
		$display("errors: checker %0d, testbench %0d", chk_errs, tb_errs);
		if (chk_errs + tb_errs == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
src/pgwr_pkg.sv
src/pgwr_upd_decode.sv
src/tbl_wr_format.sv
src/pgwr_seq_fsm.sv
src/list_ht_regs.sv
src/wr_resp_tracker.sv
src/pgwr_mngr.sv
test/pgwr_checker.sv
test/tb_pgwr_mngr.sv
